// ==== src/alu_pkg.sv ====
`default_nettype none

package alu_pkg;

    // datapath width of the integer core
    localparam int xlen = 64;

    // enough bits to shift by 0 .. xlen-1
    localparam int shamt_w = 6;

    typedef logic [xlen-1:0] xlen_t;
    typedef logic [shamt_w-1:0] shamt_t;

    // same encoding as the RISC-V funct3 field of OP / OP-IMM,
    // so the decoder can pass funct3 straight through
    typedef enum logic [2:0] {
        op_add_sub = 3'd0,
        op_sll     = 3'd1,
        op_slt     = 3'd2,
        op_sltu    = 3'd3,
        op_xor     = 3'd4,
        op_sr      = 3'd5,
        op_or      = 3'd6,
        op_and     = 3'd7
    } alu_op_e;

endpackage

`default_nettype wire

// ==== src/sklansky_adder.sv ====
`default_nettype none

module sklansky_adder (
    input  alu_pkg::xlen_t a,
    input  alu_pkg::xlen_t b,
    input  logic           c_in,
    output alu_pkg::xlen_t sum,
    output logic           c_out
);

    // log2(xlen) prefix levels
    localparam int levels = alu_pkg::shamt_w;

    // bitwise propagate, kept for the final sum
    alu_pkg::xlen_t p_bit;
    alu_pkg::xlen_t g_bit;

    // group generate / propagate after each level
    wire alu_pkg::xlen_t g_lvl [0:levels];
    wire alu_pkg::xlen_t p_lvl [0:levels-1];

    assign p_bit = a ^ b;
    assign g_bit = a & b;

    // carry in behaves like a generate into bit 0
    assign g_lvl[0] = {g_bit[alu_pkg::xlen-1:1], g_bit[0] | (p_bit[0] & c_in)};
    assign p_lvl[0] = p_bit;

    for (genvar l = 0; l < levels; l++) begin : g_level
        for (genvar i = 0; i < alu_pkg::xlen; i++) begin : g_node
            if (((i >> l) & 1) == 1) begin : g_combine
                // last bit of the neighbouring block on the right
                localparam int j = ((i >> l) << l) - 1;

                assign g_lvl[l+1][i] = g_lvl[l][i] | (p_lvl[l][i] & g_lvl[l][j]);
                if (l + 1 < levels) begin : g_prop
                    assign p_lvl[l+1][i] = p_lvl[l][i] & p_lvl[l][j];
                end
            end else begin : g_pass
                assign g_lvl[l+1][i] = g_lvl[l][i];
                if (l + 1 < levels) begin : g_prop
                    assign p_lvl[l+1][i] = p_lvl[l][i];
                end
            end
        end
    end

    // g_lvl[levels][i] is now the carry out of bit i, c_in included
    assign sum   = p_bit ^ {g_lvl[levels][alu_pkg::xlen-2:0], c_in};
    assign c_out = g_lvl[levels][alu_pkg::xlen-1];

endmodule

`default_nettype wire

// ==== src/left_barrel_shifter.sv ====
`default_nettype none

module left_barrel_shifter (
    input  alu_pkg::xlen_t  in_data,
    input  alu_pkg::shamt_t shamt,
    output alu_pkg::xlen_t  out_data
);

    // stage k shifts by 2**k when shamt[k] is set
    wire alu_pkg::xlen_t stage [0:alu_pkg::shamt_w];

    assign stage[0] = in_data;

    for (genvar k = 0; k < alu_pkg::shamt_w; k++) begin : g_stage
        localparam int sh = 1 << k;

        assign stage[k+1] = shamt[k]
            ? {stage[k][alu_pkg::xlen-1-sh:0], {sh{1'b0}}}
            : stage[k];
    end

    assign out_data = stage[alu_pkg::shamt_w];

endmodule

`default_nettype wire

// ==== src/right_barrel_shifter.sv ====
`default_nettype none

module right_barrel_shifter (
    input  alu_pkg::xlen_t  in_data,
    input  alu_pkg::shamt_t shamt,
    input  logic            arithmetic,
    output alu_pkg::xlen_t  out_data
);

    // sign bit for SRA, zero for SRL
    logic fill;

    wire alu_pkg::xlen_t stage [0:alu_pkg::shamt_w];

    assign fill     = arithmetic & in_data[alu_pkg::xlen-1];
    assign stage[0] = in_data;

    for (genvar k = 0; k < alu_pkg::shamt_w; k++) begin : g_stage
        localparam int sh = 1 << k;

        // vacated upper bits take the fill bit
        assign stage[k+1] = shamt[k]
            ? {{sh{fill}}, stage[k][alu_pkg::xlen-1:sh]}
            : stage[k];
    end

    assign out_data = stage[alu_pkg::shamt_w];

endmodule

`default_nettype wire

// ==== src/alu.sv ====
`default_nettype none

module alu (
    input  alu_pkg::xlen_t   a,
    input  alu_pkg::xlen_t   b,
    input  alu_pkg::alu_op_e op,
    input  logic             carry_in,
    input  logic             arithmetic,
    output alu_pkg::xlen_t   y,
    output logic             zero,
    output logic             negative,
    output logic             carry_out,
    output logic             overflow
);

    localparam int msb = alu_pkg::xlen - 1;

    // b as the adder sees it, inverted for subtraction
    alu_pkg::xlen_t b_eff;
    alu_pkg::xlen_t add_sub;
    alu_pkg::xlen_t sll;
    alu_pkg::xlen_t sr;
    alu_pkg::xlen_t slt;
    alu_pkg::xlen_t sltu;
    logic           adder_c_out;

    assign b_eff = b ^ {alu_pkg::xlen{carry_in}};

    // a + ~b + 1 when carry_in is set
    sklansky_adder adder (
        .a     (a),
        .b     (b_eff),
        .c_in  (carry_in),
        .sum   (add_sub),
        .c_out (adder_c_out)
    );

    left_barrel_shifter shifter_left (
        .in_data  (a),
        .shamt    (b[alu_pkg::shamt_w-1:0]),
        .out_data (sll)
    );

    right_barrel_shifter shifter_right (
        .in_data    (a),
        .shamt      (b[alu_pkg::shamt_w-1:0]),
        .arithmetic (arithmetic),
        .out_data   (sr)
    );

    // flags always come from the adder
    assign zero      = ~(|add_sub);
    assign negative  = add_sub[msb];
    assign carry_out = adder_c_out;
    // overflow uses the effective operand, so it is right for SUB too
    assign overflow  = ~(a[msb] ^ b_eff[msb]) & (a[msb] ^ add_sub[msb]);

    // signed less-than: sign of a - b corrected for overflow
    assign slt  = {{(alu_pkg::xlen-1){1'b0}}, negative ^ overflow};
    // unsigned borrow shows up as no carry out
    assign sltu = {{(alu_pkg::xlen-1){1'b0}}, ~adder_c_out};

    always_comb begin
        case (op)
            alu_pkg::op_add_sub: y = add_sub;
            alu_pkg::op_sll:     y = sll;
            alu_pkg::op_slt:     y = slt;
            alu_pkg::op_sltu:    y = sltu;
            alu_pkg::op_xor:     y = a ^ b;
            alu_pkg::op_sr:      y = sr;
            alu_pkg::op_or:      y = a | b;
            alu_pkg::op_and:     y = a & b;
            default:             y = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/alu_exec_stage.sv ====
`default_nettype none

module alu_exec_stage (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  logic [2:0]     funct3,
    input  logic           alt,
    input  logic           is_imm,
    input  alu_pkg::xlen_t rs1_data,
    input  alu_pkg::xlen_t operand_b,
    output logic           out_valid,
    output alu_pkg::xlen_t result,
    output logic           zero,
    output logic           negative,
    output logic           carry_out,
    output logic           overflow
);

    // decoded controls
    alu_pkg::alu_op_e dec_op;
    logic             dec_carry_in;
    logic             dec_arith;

    // stage 1 registers
    logic             s1_valid;
    alu_pkg::alu_op_e s1_op;
    logic             s1_carry_in;
    logic             s1_arith;
    alu_pkg::xlen_t   s1_a;
    alu_pkg::xlen_t   s1_b;

    // alu outputs
    alu_pkg::xlen_t   alu_y;
    logic             alu_zero;
    logic             alu_negative;
    logic             alu_carry_out;
    logic             alu_overflow;

    assign dec_op = alu_pkg::alu_op_e'(funct3);

    // SUB only exists as a register op; set-less-than also needs a - b
    always_comb begin
        dec_carry_in = 1'b0;
        if (dec_op == alu_pkg::op_add_sub) begin
            dec_carry_in = alt & ~is_imm;
        end else if (dec_op == alu_pkg::op_slt || dec_op == alu_pkg::op_sltu) begin
            dec_carry_in = 1'b1;
        end
    end

    // SRA / SRAI
    assign dec_arith = (dec_op == alu_pkg::op_sr) & alt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            s1_valid  <= in_valid;
            out_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_op       <= dec_op;
            s1_carry_in <= dec_carry_in;
            s1_arith    <= dec_arith;
            s1_a        <= rs1_data;
            s1_b        <= operand_b;
        end
    end

    alu u_alu (
        .a          (s1_a),
        .b          (s1_b),
        .op         (s1_op),
        .carry_in   (s1_carry_in),
        .arithmetic (s1_arith),
        .y          (alu_y),
        .zero       (alu_zero),
        .negative   (alu_negative),
        .carry_out  (alu_carry_out),
        .overflow   (alu_overflow)
    );

    // result registers hold the last value between operations
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            result    <= alu_y;
            zero      <= alu_zero;
            negative  <= alu_negative;
            carry_out <= alu_carry_out;
            overflow  <= alu_overflow;
        end
    end

endmodule

`default_nettype wire

// ==== include/alu_ref_model.svh ====
`ifndef ALU_REF_MODEL_SVH
`define ALU_REF_MODEL_SVH

// behavioral model of one execute-stage operation
// flags describe the adder, with the same add/subtract choice as the decoder
function automatic void alu_ref_model(
    input  logic [2:0]     funct3,
    input  logic           alt,
    input  logic           is_imm,
    input  alu_pkg::xlen_t a,
    input  alu_pkg::xlen_t b,
    output alu_pkg::xlen_t y,
    output logic           zero,
    output logic           negative,
    output logic           carry_out,
    output logic           overflow
);
    alu_pkg::alu_op_e op;
    logic             sub;
    alu_pkg::xlen_t   b_eff;
    logic [64:0]      sum65;
    alu_pkg::xlen_t   sum;
    alu_pkg::shamt_t  shamt;

    op    = alu_pkg::alu_op_e'(funct3);
    shamt = b[alu_pkg::shamt_w-1:0];

    // SUB, SLT and SLTU go through a - b in the adder
    case (op)
        alu_pkg::op_add_sub: sub = alt & ~is_imm;
        alu_pkg::op_slt:     sub = 1'b1;
        alu_pkg::op_sltu:    sub = 1'b1;
        default:             sub = 1'b0;
    endcase

    b_eff = sub ? ~b : b;
    sum65 = {1'b0, a} + {1'b0, b_eff} + {64'd0, sub};
    sum   = sum65[63:0];

    zero      = (sum == '0);
    negative  = sum[63];
    carry_out = sum65[64];
    overflow  = (a[63] == b_eff[63]) && (sum[63] != a[63]);

    case (op)
        alu_pkg::op_add_sub: y = sum;
        alu_pkg::op_sll:     y = a << shamt;
        alu_pkg::op_slt:     y = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
        alu_pkg::op_sltu:    y = (a < b) ? 64'd1 : 64'd0;
        alu_pkg::op_xor:     y = a ^ b;
        alu_pkg::op_sr: begin
            if (alt) begin
                y = $signed(a) >>> shamt;
            end else begin
                y = a >> shamt;
            end
        end
        alu_pkg::op_or:      y = a | b;
        alu_pkg::op_and:     y = a & b;
        default:             y = '0;
    endcase
endfunction

`endif

// ==== tb/tb_alu_exec_stage.sv ====
`default_nettype none

module tb_alu_exec_stage;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_half      = 50;
    localparam int drive_delay   = 5;
    localparam int reset_cycles  = 4;
    localparam int drain_timeout = 50;
    localparam int random_ops    = 400;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    logic [2:0]     funct3;
    logic           alt;
    logic           is_imm;
    alu_pkg::xlen_t rs1_data;
    alu_pkg::xlen_t operand_b;
    logic           out_valid;
    alu_pkg::xlen_t result;
    logic           zero;
    logic           negative;
    logic           carry_out;
    logic           overflow;

    // expected responses, oldest first
    alu_pkg::xlen_t exp_result_q [$];
    logic [3:0]     exp_flags_q [$];
    int             exp_cycle_q [$];

    logic [31:0] rng_state = 32'h79ee152e;
    int          cycle_count = 0;
    int          checks = 0;
    int          value_errors = 0;
    int          other_errors = 0;

    `include "alu_ref_model.svh"

    alu_exec_stage uut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .funct3    (funct3),
        .alt       (alt),
        .is_imm    (is_imm),
        .rs1_data  (rs1_data),
        .operand_b (operand_b),
        .out_valid (out_valid),
        .result    (result),
        .zero      (zero),
        .negative  (negative),
        .carry_out (carry_out),
        .overflow  (overflow)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #clk_half clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic alu_pkg::xlen_t rand64();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi, lo};
    endfunction

    function automatic alu_pkg::xlen_t sext12(input logic [11:0] v);
        return {{52{v[11]}}, v};
    endfunction

    task automatic compare_field(input string name, input logic [63:0] actual,
                                 input logic [63:0] expected);
        assert (actual === expected) else begin
            value_errors++;
            $display("ERROR %s: expected %0h, got %0h", name, expected, actual);
        end
    endtask

    // one operation, sampled by the DUT on the next rising edge
    task automatic issue_op(input logic [2:0] f3, input logic alt_bit, input logic imm_bit,
                            input alu_pkg::xlen_t a, input alu_pkg::xlen_t b);
        alu_pkg::xlen_t y;
        logic           z;
        logic           n;
        logic           c;
        logic           v;
        @(posedge clk);
        #drive_delay;
        in_valid  = 1'b1;
        funct3    = f3;
        alt       = alt_bit;
        is_imm    = imm_bit;
        rs1_data  = a;
        operand_b = b;
        alu_ref_model(f3, alt_bit, imm_bit, a, b, y, z, n, c, v);
        exp_result_q.push_back(y);
        exp_flags_q.push_back({z, n, c, v});
        // sampled one edge from now, result registered on the edge after
        exp_cycle_q.push_back(cycle_count + 2);
    endtask

    task automatic idle_cycles(input int n);
        logic [31:0] r;
        repeat (n) begin
            @(posedge clk);
            #drive_delay;
            r         = next_rand();
            in_valid  = 1'b0;
            funct3    = r[2:0];
            alt       = r[3];
            is_imm    = r[4];
            // garbage on the data inputs must not reach the pipeline
            rs1_data  = rand64();
            operand_b = rand64();
        end
    endtask

    task automatic reg_op(input logic [2:0] f3, input logic alt_bit,
                          input alu_pkg::xlen_t a, input alu_pkg::xlen_t b);
        issue_op(f3, alt_bit, 1'b0, a, b);
    endtask

    // alt follows immediate bit 10
    task automatic imm_op(input logic [2:0] f3, input alu_pkg::xlen_t a,
                          input logic [11:0] imm);
        alu_pkg::xlen_t b;
        b = sext12(imm);
        issue_op(f3, b[10], 1'b1, a, b);
    endtask

    task automatic shift_imm_op(input logic [2:0] f3, input logic arith,
                                input alu_pkg::xlen_t a, input alu_pkg::shamt_t shamt);
        imm_op(f3, a, {1'b0, arith, 4'b0000, shamt});
    endtask

    task automatic random_op();
        logic [31:0]    r;
        logic [2:0]     f3;
        logic           alt_bit;
        alu_pkg::xlen_t a;
        alu_pkg::xlen_t b;
        r       = next_rand();
        f3      = r[2:0];
        alt_bit = r[4];
        a       = rand64();
        b       = rand64();
        if (r[7:5] == 3'd0) begin
            b = a;
        end
        if (r[3]) begin
            if (f3 == 3'd1 || f3 == 3'd5) begin
                shift_imm_op(f3, (f3 == 3'd5) && alt_bit, a, b[5:0]);
            end else begin
                imm_op(f3, a, b[11:0]);
            end
        end else begin
            if (f3 != 3'd0 && f3 != 3'd5) begin
                alt_bit = 1'b0;
            end
            reg_op(f3, alt_bit, a, b);
        end
    endtask

    initial begin : compare_outputs
        alu_pkg::xlen_t exp_result;
        logic [3:0]     exp_flags;
        int             exp_cycle;
        forever begin
            @(negedge clk);
            if (rst_n !== 1'b1) begin
                compare_field("out_valid", out_valid, 64'd0);
            end else if (out_valid === 1'b1) begin
                if (exp_result_q.size() == 0) begin
                    other_errors++;
                    $display("out_valid high at cycle %0d with no operation in flight",
                             cycle_count);
                end else begin
                    exp_result = exp_result_q.pop_front();
                    exp_flags  = exp_flags_q.pop_front();
                    exp_cycle  = exp_cycle_q.pop_front();
                    checks++;
                    assert (cycle_count == exp_cycle) else begin
                        other_errors++;
                        $display("result came at cycle %0d but was due at cycle %0d",
                                 cycle_count, exp_cycle);
                    end
                    compare_field("result", result, exp_result);
                    compare_field("zero", zero, exp_flags[3]);
                    compare_field("negative", negative, exp_flags[2]);
                    compare_field("carry_out", carry_out, exp_flags[1]);
                    compare_field("overflow", overflow, exp_flags[0]);
                end
            end else if (exp_cycle_q.size() != 0 && exp_cycle_q[0] <= cycle_count) begin
                other_errors++;
                $display("no result at cycle %0d where one was due", cycle_count);
                exp_result = exp_result_q.pop_front();
                exp_flags  = exp_flags_q.pop_front();
                exp_cycle  = exp_cycle_q.pop_front();
            end
        end
    end

    initial begin : stimulus
        alu_pkg::xlen_t  a;
        alu_pkg::xlen_t  b;
        alu_pkg::shamt_t sh;
        logic [31:0]     r;
        int              i;
        in_valid  = 1'b0;
        funct3    = 3'd0;
        alt       = 1'b0;
        is_imm    = 1'b0;
        rs1_data  = '0;
        operand_b = '0;
        rst_n     = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst_n = 1'b1;
        // idle after reset, out_valid must stay low
        idle_cycles(5);

        // add and subtract corners
        reg_op(3'd0, 1'b0, 64'h7fff_ffff_ffff_ffff, 64'd1);
        reg_op(3'd0, 1'b1, 64'h8000_0000_0000_0000, 64'd1);
        reg_op(3'd0, 1'b0, 64'hffff_ffff_ffff_ffff, 64'd1);
        reg_op(3'd0, 1'b0, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000);
        a = rand64();
        reg_op(3'd0, 1'b1, a, a);
        reg_op(3'd0, 1'b1, 64'd0, 64'd1);
        imm_op(3'd0, 64'h8000_0000_0000_0000, 12'hfff);
        imm_op(3'd0, 64'h7fff_ffff_ffff_fc00, 12'h400);
        imm_op(3'd0, 64'd5, 12'hffb);
        for (i = 0; i < 20; i++) begin
            reg_op(3'd0, 1'b0, rand64(), rand64());
            reg_op(3'd0, 1'b1, rand64(), rand64());
            r = next_rand();
            imm_op(3'd0, rand64(), r[11:0]);
        end
        idle_cycles(3);

        // shifts, high bits of operand_b must be ignored
        for (i = 0; i < 8; i++) begin
            r = next_rand();
            if (i == 0) begin
                sh = 6'd0;
            end else if (i == 1) begin
                sh = 6'd63;
            end else begin
                sh = r[5:0];
            end
            a = rand64();
            if (i[0]) begin
                a[63] = 1'b1;
            end
            // random upper bits above the shift amount
            b      = rand64();
            b[5:0] = sh;
            reg_op(3'd1, 1'b0, a, b);
            reg_op(3'd5, 1'b0, a, b);
            reg_op(3'd5, 1'b1, a, b);
            shift_imm_op(3'd1, 1'b0, a, sh);
            shift_imm_op(3'd5, 1'b0, a, sh);
            shift_imm_op(3'd5, 1'b1, a, sh);
        end
        reg_op(3'd5, 1'b1, 64'h8000_0000_0000_0001, 64'd63);
        idle_cycles(2);

        // signed and unsigned compares disagree on mixed signs
        for (i = 2; i <= 3; i++) begin
            reg_op(i[2:0], 1'b0, 64'hffff_ffff_ffff_ffff, 64'd1);
            reg_op(i[2:0], 1'b0, 64'd1, 64'hffff_ffff_ffff_ffff);
            reg_op(i[2:0], 1'b0, 64'h8000_0000_0000_0000, 64'h7fff_ffff_ffff_ffff);
            reg_op(i[2:0], 1'b0, 64'h7fff_ffff_ffff_ffff, 64'h8000_0000_0000_0000);
            a = rand64();
            reg_op(i[2:0], 1'b0, a, a);
            reg_op(i[2:0], 1'b0, 64'd0, 64'd0);
            imm_op(i[2:0], 64'd1, 12'hfff);
            imm_op(i[2:0], 64'hffff_ffff_ffff_ffff, 12'h001);
            imm_op(i[2:0], 64'hffff_ffff_ffff_ffff, 12'hfff);
        end
        idle_cycles(2);

        // logic operations
        for (i = 0; i < 20; i++) begin
            r = next_rand();
            reg_op(3'd4, 1'b0, rand64(), rand64());
            reg_op(3'd6, 1'b0, rand64(), rand64());
            reg_op(3'd7, 1'b0, rand64(), rand64());
            imm_op(3'd4, rand64(), r[11:0]);
            imm_op(3'd6, rand64(), r[23:12]);
            imm_op(3'd7, rand64(), r[31:20]);
        end
        idle_cycles(1);

        // back to back with random gaps
        for (i = 0; i < random_ops; i++) begin
            random_op();
            r = next_rand();
            if (r[1:0] == 2'd0) begin
                idle_cycles(1 + (r[3:2] % 3));
            end
        end
        idle_cycles(1);

        for (i = 0; i < drain_timeout && exp_result_q.size() != 0; i++) begin
            @(posedge clk);
        end
        if (exp_result_q.size() != 0) begin
            other_errors++;
            $display("timed out with %0d results still outstanding", exp_result_q.size());
        end
        idle_cycles(2);

        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0 && checks > 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim.f ====
+incdir+include
src/alu_pkg.sv
src/sklansky_adder.sv
src/left_barrel_shifter.sv
src/right_barrel_shifter.sv
src/alu.sv
src/alu_exec_stage.sv
tb/tb_alu_exec_stage.sv
